// File: rtl/io_macros.svh
// I/O subsystem sizing, register map and fixed JTAG pad positions
// Shared by the RTL and the testbench

`ifndef IO_MACROS_SVH
`define IO_MACROS_SVH

////////////////////////////////////////
// Sizes
////////////////////////////////////////

`define IO_NUM_MIO     8   // Multiplexed pads
`define IO_NUM_PERIPH  8   // Peripheral slots per direction
`define IO_SEL_W       4   // Select code width
`define IO_ADDR_W      5
`define IO_DATA_W      8

////////////////////////////////////////
// Register map
////////////////////////////////////////

`define IO_ADDR_OUTSEL 0   // Output select of pad k at base + k
`define IO_ADDR_INSEL  8   // Input select of peripheral k
`define IO_ADDR_ATTR   16  // Pad attributes
`define IO_ADDR_STATUS 24  // Read-only, bit 0 is jtag_en

// Debug pads taken over by the JTAG overlay
`define IO_JTAG_TCK_IDX   0
`define IO_JTAG_TMS_IDX   1
`define IO_JTAG_TDI_IDX   2
`define IO_JTAG_TDO_IDX   3
`define IO_JTAG_TRST_IDX  4

`define IO_JTAG_STRAP_IDX 7   // Sampled once after reset

`endif

// File: rtl/io_pkg.sv
// Types shared by the I/O subsystem
// Pad attributes and the register data word with its two decodings

`include "io_macros.svh"

package io_pkg;

  // Per-pad attributes, applied in the pad ring
  typedef struct packed {
    logic input_dis;   // Core sees 0
    logic open_drain;  // Only drive low
    logic invert;      // Both directions
  } io_attr_t;

  localparam int IO_ATTR_W = $bits(io_attr_t);

  // Register data word
  // Select registers use the sel view, attribute registers the attr view
  typedef union packed {
    struct packed {
      logic [`IO_DATA_W-`IO_SEL_W-1:0] rsvd;
      logic [`IO_SEL_W-1:0]            value;
    } sel;
    struct packed {
      logic [`IO_DATA_W-IO_ATTR_W-1:0] rsvd;
      io_attr_t                        value;
    } attr;
  } io_reg_word_u;

endpackage : io_pkg

// File: rtl/io_ctrl.sv
// I/O control block
// Register file for pad routing and attributes, plus the JTAG strap sampler

`include "io_macros.svh"

module io_ctrl
  import io_pkg::*;
(
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  // Register port
  input  logic                                       reg_we_i,
  input  logic                                       reg_re_i,
  input  logic [`IO_ADDR_W-1:0]                      reg_addr_i,
  input  logic [`IO_DATA_W-1:0]                      reg_wdata_i,
  output logic [`IO_DATA_W-1:0]                      reg_rdata_o,
  // Strap pad, seen after the pad ring
  input  logic                                       strap_i,
  // Configuration to the datapath
  output logic [`IO_NUM_MIO-1:0][`IO_SEL_W-1:0]      outsel_o,
  output logic [`IO_NUM_PERIPH-1:0][`IO_SEL_W-1:0]   insel_o,
  output io_attr_t [`IO_NUM_MIO-1:0]                 attr_o,
  output logic                                       jtag_en_o
);

  localparam int ADDR_W = `IO_ADDR_W;
  localparam int IDX_W  = $clog2(`IO_NUM_MIO);  // Registers per bank
  localparam int BANK_W = ADDR_W - IDX_W;

  localparam logic [BANK_W-1:0] BANK_OUTSEL = BANK_W'(`IO_ADDR_OUTSEL / `IO_NUM_MIO);
  localparam logic [BANK_W-1:0] BANK_INSEL  = BANK_W'(`IO_ADDR_INSEL / `IO_NUM_MIO);
  localparam logic [BANK_W-1:0] BANK_ATTR   = BANK_W'(`IO_ADDR_ATTR / `IO_NUM_MIO);

  logic [`IO_NUM_MIO-1:0][`IO_SEL_W-1:0]    outsel_q;
  logic [`IO_NUM_PERIPH-1:0][`IO_SEL_W-1:0] insel_q;
  io_attr_t [`IO_NUM_MIO-1:0]               attr_q;
  logic [`IO_DATA_W-1:0]                    rdata_q;
  logic                                     strap_done_q;
  logic                                     jtag_en_q;

  logic [IDX_W-1:0]  idx;
  logic [BANK_W-1:0] bank;
  logic              hit_outsel, hit_insel, hit_attr, hit_status;
  io_reg_word_u      wword;
  io_reg_word_u      rword;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign idx  = reg_addr_i[IDX_W-1:0];
  assign bank = reg_addr_i[ADDR_W-1:IDX_W];

  assign hit_outsel = (bank == BANK_OUTSEL);
  assign hit_insel  = (bank == BANK_INSEL);
  assign hit_attr   = (bank == BANK_ATTR);
  assign hit_status = (reg_addr_i == ADDR_W'(`IO_ADDR_STATUS));

  assign wword = reg_wdata_i;

  // Only the decoded field is kept, reserved bits drop here
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outsel_q <= '0;
      insel_q  <= '0;
      attr_q   <= '0;
    end else if (reg_we_i) begin
      if (hit_outsel) outsel_q[idx] <= wword.sel.value;
      if (hit_insel)  insel_q[idx]  <= wword.sel.value;
      if (hit_attr)   attr_q[idx]   <= wword.attr.value;
    end
  end

  ////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////

  always_comb begin
    rword = '0;  // Unmapped reads return 0
    if (hit_outsel) begin
      rword.sel.value = outsel_q[idx];
    end else if (hit_insel) begin
      rword.sel.value = insel_q[idx];
    end else if (hit_attr) begin
      rword.attr.value = attr_q[idx];
    end else if (hit_status) begin
      rword = {{(`IO_DATA_W-1){1'b0}}, jtag_en_q};
    end
  end

  // Held until the next read
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (reg_re_i) begin
      rdata_q <= rword;
    end
  end

  // One-shot strap capture on the first edge out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strap_done_q <= 1'b0;
      jtag_en_q    <= 1'b0;
    end else if (!strap_done_q) begin
      strap_done_q <= 1'b1;
      jtag_en_q    <= strap_i;
    end
  end

  assign reg_rdata_o = rdata_q;
  assign outsel_o    = outsel_q;
  assign insel_o     = insel_q;
  assign attr_o      = attr_q;
  assign jtag_en_o   = jtag_en_q;

endmodule : io_ctrl

// File: rtl/pin_mux.sv
// Pin multiplexer
// Routes peripheral outputs onto pads and pad inputs onto peripheral inputs

`include "io_macros.svh"

module pin_mux (
  input  logic [`IO_NUM_MIO-1:0][`IO_SEL_W-1:0]    outsel_i,
  input  logic [`IO_NUM_PERIPH-1:0][`IO_SEL_W-1:0] insel_i,
  // Peripheral side
  input  logic [`IO_NUM_PERIPH-1:0]                periph_out_i,
  input  logic [`IO_NUM_PERIPH-1:0]                periph_oe_i,
  output logic [`IO_NUM_PERIPH-1:0]                periph_in_o,
  // Core side of the pads
  input  logic [`IO_NUM_MIO-1:0]                   core_in_i,
  output logic [`IO_NUM_MIO-1:0]                   core_out_o,
  output logic [`IO_NUM_MIO-1:0]                   core_oe_o
);

  // Wide enough for either source bus
  localparam int SRC_W = (`IO_NUM_MIO > `IO_NUM_PERIPH) ? `IO_NUM_MIO : `IO_NUM_PERIPH;

  // Code v picks source v-1, code 0 and codes past the end give 0
  function automatic logic pick(input logic [`IO_SEL_W-1:0] sel,
                                input logic [SRC_W-1:0]     src);
    logic res;
    res = 1'b0;
    for (int i = 0; i < SRC_W; i++) begin
      if (sel == `IO_SEL_W'(i + 1)) res = src[i];
    end
    return res;
  endfunction

  logic [SRC_W-1:0] periph_out_ext, periph_oe_ext, core_in_ext;

  // Zero fill keeps codes beyond a short bus at 0
  assign periph_out_ext = SRC_W'(periph_out_i);
  assign periph_oe_ext  = SRC_W'(periph_oe_i);
  assign core_in_ext    = SRC_W'(core_in_i);

  // Output direction, out and oe follow the same peripheral
  always_comb begin
    for (int k = 0; k < `IO_NUM_MIO; k++) begin
      core_out_o[k] = pick(outsel_i[k], periph_out_ext);
      core_oe_o[k]  = pick(outsel_i[k], periph_oe_ext);
    end
  end

  // Input direction
  always_comb begin
    for (int p = 0; p < `IO_NUM_PERIPH; p++) begin
      periph_in_o[p] = pick(insel_i[p], core_in_ext);
    end
  end

endmodule : pin_mux

// File: rtl/jtag_mux.sv
// JTAG overlay mux
// Takes the fixed debug pads when enabled and ties off their core-side view

`include "io_macros.svh"

module jtag_mux (
  input  logic                   jtag_en_i,
  // Debug port
  output logic                   jtag_tck_o,
  output logic                   jtag_tms_o,
  output logic                   jtag_tdi_o,
  output logic                   jtag_trst_n_o,
  input  logic                   jtag_tdo_i,
  // Core side
  input  logic [`IO_NUM_MIO-1:0] core_out_i,
  input  logic [`IO_NUM_MIO-1:0] core_oe_i,
  output logic [`IO_NUM_MIO-1:0] core_in_o,
  // Pad ring side
  output logic [`IO_NUM_MIO-1:0] pad_out_o,
  output logic [`IO_NUM_MIO-1:0] pad_oe_o,
  input  logic [`IO_NUM_MIO-1:0] pad_in_i
);

  localparam int N = `IO_NUM_MIO;

  // Pads owned by the debug port while enabled
  localparam logic [N-1:0] JTAG_MASK = (N'(1) << `IO_JTAG_TCK_IDX)
                                     | (N'(1) << `IO_JTAG_TMS_IDX)
                                     | (N'(1) << `IO_JTAG_TDI_IDX)
                                     | (N'(1) << `IO_JTAG_TDO_IDX)
                                     | (N'(1) << `IO_JTAG_TRST_IDX);

  // Core reads these while the overlay is on, TMS idles high
  localparam logic [N-1:0] TIE_OFF = N'(1) << `IO_JTAG_TMS_IDX;

  always_comb begin
    // Pass-through by default
    pad_out_o = core_out_i;
    pad_oe_o  = core_oe_i;
    core_in_o = pad_in_i;

    // Idle debug levels
    jtag_tck_o    = 1'b0;
    jtag_tms_o    = 1'b1;
    jtag_tdi_o    = 1'b0;
    jtag_trst_n_o = 1'b0;

    if (jtag_en_i) begin
      pad_out_o = core_out_i & ~JTAG_MASK;
      pad_oe_o  = core_oe_i & ~JTAG_MASK;  // Debug inputs float
      pad_out_o[`IO_JTAG_TDO_IDX] = jtag_tdo_i;
      pad_oe_o[`IO_JTAG_TDO_IDX]  = 1'b1;

      core_in_o = (pad_in_i & ~JTAG_MASK) | TIE_OFF;

      jtag_tck_o    = pad_in_i[`IO_JTAG_TCK_IDX];
      jtag_tms_o    = pad_in_i[`IO_JTAG_TMS_IDX];
      jtag_tdi_o    = pad_in_i[`IO_JTAG_TDI_IDX];
      jtag_trst_n_o = pad_in_i[`IO_JTAG_TRST_IDX];
    end
  end

endmodule : jtag_mux

// File: rtl/pad_ring.sv
// Pad ring model
// Applies invert, open-drain and input-disable per pad

`include "io_macros.svh"

module pad_ring
  import io_pkg::*;
(
  input  io_attr_t [`IO_NUM_MIO-1:0] attr_i,
  // Core side
  input  logic [`IO_NUM_MIO-1:0]     core_out_i,
  input  logic [`IO_NUM_MIO-1:0]     core_oe_i,
  output logic [`IO_NUM_MIO-1:0]     core_in_o,
  // Pad side, split in, out and enable
  input  logic [`IO_NUM_MIO-1:0]     mio_in_i,
  output logic [`IO_NUM_MIO-1:0]     mio_out_o,
  output logic [`IO_NUM_MIO-1:0]     mio_oe_o
);

  ////////////////////////////////////////
  // Output path
  ////////////////////////////////////////

  always_comb begin
    logic out_inv;
    for (int k = 0; k < `IO_NUM_MIO; k++) begin
      out_inv = core_out_i[k] ^ attr_i[k].invert;
      if (attr_i[k].open_drain) begin
        // Pull low only, release for a one
        mio_out_o[k] = 1'b0;
        mio_oe_o[k]  = core_oe_i[k] & ~out_inv;
      end else begin
        mio_out_o[k] = out_inv;
        mio_oe_o[k]  = core_oe_i[k];
      end
    end
  end

  ////////////////////////////////////////
  // Input path
  ////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < `IO_NUM_MIO; k++) begin
      if (attr_i[k].input_dis) begin
        core_in_o[k] = 1'b0;
      end else begin
        core_in_o[k] = mio_in_i[k] ^ attr_i[k].invert;
      end
    end
  end

endmodule : pad_ring

// File: rtl/io_subsys_top.sv
// I/O subsystem top level
// Control block, pin mux, JTAG overlay and pad ring in one wrapper

`include "io_macros.svh"

module io_subsys_top
  import io_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Register port
  input  logic                      reg_we_i,
  input  logic                      reg_re_i,
  input  logic [`IO_ADDR_W-1:0]     reg_addr_i,
  input  logic [`IO_DATA_W-1:0]     reg_wdata_i,
  output logic [`IO_DATA_W-1:0]     reg_rdata_o,
  // Peripheral slots
  input  logic [`IO_NUM_PERIPH-1:0] periph_out_i,
  input  logic [`IO_NUM_PERIPH-1:0] periph_oe_i,
  output logic [`IO_NUM_PERIPH-1:0] periph_in_o,
  // Pads
  input  logic [`IO_NUM_MIO-1:0]    mio_in_i,
  output logic [`IO_NUM_MIO-1:0]    mio_out_o,
  output logic [`IO_NUM_MIO-1:0]    mio_oe_o,
  // Debug port
  output logic                      jtag_tck_o,
  output logic                      jtag_tms_o,
  output logic                      jtag_tdi_o,
  output logic                      jtag_trst_n_o,
  input  logic                      jtag_tdo_i
);

  logic [`IO_NUM_MIO-1:0][`IO_SEL_W-1:0]    outsel;
  logic [`IO_NUM_PERIPH-1:0][`IO_SEL_W-1:0] insel;
  io_attr_t [`IO_NUM_MIO-1:0]               attr;
  logic                                     jtag_en;

  logic [`IO_NUM_MIO-1:0] mux_out, mux_oe, mux_in;  // pin_mux <-> jtag_mux
  logic [`IO_NUM_MIO-1:0] ring_out, ring_oe, ring_in;  // jtag_mux <-> pad_ring

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  io_ctrl io_ctrl_i (
    .clk_i       ( clk_i                          ),
    .rst_n_i     ( rst_n_i                        ),
    .reg_we_i    ( reg_we_i                       ),
    .reg_re_i    ( reg_re_i                       ),
    .reg_addr_i  ( reg_addr_i                     ),
    .reg_wdata_i ( reg_wdata_i                    ),
    .reg_rdata_o ( reg_rdata_o                    ),
    .strap_i     ( ring_in[`IO_JTAG_STRAP_IDX]    ),  // After pad attributes
    .outsel_o    ( outsel                         ),
    .insel_o     ( insel                          ),
    .attr_o      ( attr                           ),
    .jtag_en_o   ( jtag_en                        )
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  pin_mux pin_mux_i (
    .outsel_i     ( outsel       ),
    .insel_i      ( insel        ),
    .periph_out_i ( periph_out_i ),
    .periph_oe_i  ( periph_oe_i  ),
    .periph_in_o  ( periph_in_o  ),
    .core_in_i    ( mux_in       ),
    .core_out_o   ( mux_out      ),
    .core_oe_o    ( mux_oe       )
  );

  jtag_mux jtag_mux_i (
    .jtag_en_i     ( jtag_en       ),
    .jtag_tck_o    ( jtag_tck_o    ),
    .jtag_tms_o    ( jtag_tms_o    ),
    .jtag_tdi_o    ( jtag_tdi_o    ),
    .jtag_trst_n_o ( jtag_trst_n_o ),
    .jtag_tdo_i    ( jtag_tdo_i    ),
    .core_out_i    ( mux_out       ),
    .core_oe_i     ( mux_oe        ),
    .core_in_o     ( mux_in        ),
    .pad_out_o     ( ring_out      ),
    .pad_oe_o      ( ring_oe       ),
    .pad_in_i      ( ring_in       )
  );

  pad_ring pad_ring_i (
    .attr_i     ( attr      ),
    .core_out_i ( ring_out  ),
    .core_oe_i  ( ring_oe   ),
    .core_in_o  ( ring_in   ),
    .mio_in_i   ( mio_in_i  ),
    .mio_out_o  ( mio_out_o ),
    .mio_oe_o   ( mio_oe_o  )
  );

endmodule : io_subsys_top

// File: sim/io_subsys_tb.sv
// Testbench for the I/O subsystem
// Compares the DUT against a model of routing, pad attributes and the JTAG overlay

`include "io_macros.svh"

module io_subsys_tb
  import io_pkg::*;
();

  localparam int N       = `IO_NUM_MIO;
  localparam int TIMEOUT = 50;  // Status polls before giving up

  logic                     clk, rst_n, reg_we, reg_re;
  logic [`IO_ADDR_W-1:0]    reg_addr;
  logic [`IO_DATA_W-1:0]    reg_wdata, reg_rdata;
  logic [`IO_NUM_PERIPH-1:0] periph_out, periph_oe, periph_in;
  logic [N-1:0]             mio_in, mio_out, mio_oe;
  logic                     jtag_tck, jtag_tms, jtag_tdi, jtag_trst_n, jtag_tdo;

  // Reference state
  logic [`IO_SEL_W-1:0] ref_outsel [N];
  logic [`IO_SEL_W-1:0] ref_insel [`IO_NUM_PERIPH];
  io_attr_t             ref_attr [N];
  logic                 ref_jtag_en;
  logic                 status_ok;
  integer               seed;
  int                   err_cnt, chk_cnt;

  io_subsys_top io_subsys_top_i (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .reg_we_i      ( reg_we      ),
    .reg_re_i      ( reg_re      ),
    .reg_addr_i    ( reg_addr    ),
    .reg_wdata_i   ( reg_wdata   ),
    .reg_rdata_o   ( reg_rdata   ),
    .periph_out_i  ( periph_out  ),
    .periph_oe_i   ( periph_oe   ),
    .periph_in_o   ( periph_in   ),
    .mio_in_i      ( mio_in      ),
    .mio_out_o     ( mio_out     ),
    .mio_oe_o      ( mio_oe      ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_tdi_o    ( jtag_tdi    ),
    .jtag_trst_n_o ( jtag_trst_n ),
    .jtag_tdo_i    ( jtag_tdo    )
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // Pad inputs after invert and input disable
  function automatic logic [N-1:0] ring_in_model();
    logic [N-1:0] v;
    for (int k = 0; k < N; k++) begin
      v[k] = ref_attr[k].input_dis ? 1'b0 : (mio_in[k] ^ ref_attr[k].invert);
    end
    return v;
  endfunction

  function automatic logic [`IO_NUM_PERIPH-1:0] route_inputs();
    logic [N-1:0]              core;
    logic [`IO_NUM_PERIPH-1:0] v;
    int                        s;
    core = ring_in_model();
    if (ref_jtag_en) begin  // Debug pads tied off and TMS reads 1
      core[`IO_JTAG_TCK_IDX]  = 1'b0;
      core[`IO_JTAG_TMS_IDX]  = 1'b1;
      core[`IO_JTAG_TDI_IDX]  = 1'b0;
      core[`IO_JTAG_TDO_IDX]  = 1'b0;
      core[`IO_JTAG_TRST_IDX] = 1'b0;
    end
    for (int p = 0; p < `IO_NUM_PERIPH; p++) begin
      s    = int'(ref_insel[p]);
      v[p] = (s >= 1 && s <= N) ? core[s-1] : 1'b0;
    end
    return v;
  endfunction

  // Expected pad outputs
  // Care bits mark pads with a defined out value
  task automatic compute_pads(output logic [N-1:0] out, oe, care);
    logic c_out, c_oe, inv;
    int   s;
    care = '1;
    for (int k = 0; k < N; k++) begin
      s    = int'(ref_outsel[k]);
      c_out = (s >= 1 && s <= `IO_NUM_PERIPH) ? periph_out[s-1] : 1'b0;
      c_oe  = (s >= 1 && s <= `IO_NUM_PERIPH) ? periph_oe[s-1] : 1'b0;
      if (ref_jtag_en && k == `IO_JTAG_TDO_IDX) begin
        c_out = jtag_tdo;
        c_oe  = 1'b1;
      end else if (ref_jtag_en && k <= `IO_JTAG_TRST_IDX) begin
        c_oe    = 1'b0;
        care[k] = 1'b0;
      end
      inv   = c_out ^ ref_attr[k].invert;
      out[k] = ref_attr[k].open_drain ? 1'b0 : inv;
      oe[k]  = ref_attr[k].open_drain ? (c_oe & ~inv) : c_oe;
    end
  endtask

  function automatic logic [7:0] reg_model(input logic [`IO_ADDR_W-1:0] a);
    if (a < `IO_ADDR_INSEL) return {4'b0, ref_outsel[a[2:0]]};
    if (a < `IO_ADDR_ATTR) return {4'b0, ref_insel[a[2:0]]};
    if (a < `IO_ADDR_STATUS) return {5'b0, ref_attr[a[2:0]]};
    if (a == `IO_ADDR_STATUS) return {7'b0, ref_jtag_en};
    return 8'h00;
  endfunction

  ////////////////////////////////////////
  // Checks and bus tasks
  ////////////////////////////////////////

  task automatic expect_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("error %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_datapath();
    logic [N-1:0] exp_out, exp_oe, care, ring;
    logic [3:0]   exp_dbg;
    compute_pads(exp_out, exp_oe, care);
    ring    = ring_in_model();
    exp_dbg = ref_jtag_en ? {ring[0], ring[1], ring[2], ring[4]} : 4'b0100;  // Idle levels
    expect_eq("mio_oe_o", mio_oe, exp_oe);
    expect_eq("mio_out_o", mio_out & care, exp_out & care);
    expect_eq("periph_in_o", periph_in, route_inputs());
    expect_eq("jtag tck/tms/tdi/trst_n", {4'b0, jtag_tck, jtag_tms, jtag_tdi, jtag_trst_n},
              {4'b0, exp_dbg});
  endtask

  task automatic program_reg(input logic [`IO_ADDR_W-1:0] a, input logic [7:0] d);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = a;
    reg_wdata = d;
    @(negedge clk);
    reg_we = 1'b0;
    if (a < `IO_ADDR_INSEL) ref_outsel[a[2:0]] = d[3:0];
    else if (a < `IO_ADDR_ATTR) ref_insel[a[2:0]] = d[3:0];
    else if (a < `IO_ADDR_STATUS) ref_attr[a[2:0]] = d[2:0];
  endtask

  task automatic reg_read(input logic [`IO_ADDR_W-1:0] a, output logic [7:0] d);
    @(negedge clk);
    reg_re   = 1'b1;
    reg_addr = a;
    @(negedge clk);
    reg_re = 1'b0;
    d      = reg_rdata;
  endtask

  task automatic read_and_check(input logic [`IO_ADDR_W-1:0] a);
    logic [7:0] d;
    reg_read(a, d);
    expect_eq("reg_rdata_o", d, reg_model(a));
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // Strap level sits on pad 7 while reset is held
  task automatic apply_reset(input logic strap);
    @(negedge clk);
    rst_n  = 1'b0;
    mio_in = {strap, 7'b0};
    for (int k = 0; k < N; k++) begin
      ref_outsel[k] = '0;
      ref_insel[k]  = '0;
      ref_attr[k]   = '0;
    end
    ref_jtag_en = strap;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic wait_status(input logic exp, output logic ok);
    logic [7:0] d;
    int         n;
    n = 1;
    reg_read(`IO_ADDR_STATUS, d);
    while (d[0] !== exp && n < TIMEOUT) begin
      reg_read(`IO_ADDR_STATUS, d);
      n++;
    end
    ok = (d[0] === exp);
    if (!ok) begin
      $display("Timeout: status register never showed jtag_en = %0b", exp);
      err_cnt++;
    end
  endtask

  task automatic drive_and_check();
    logic [7:0] r;
    @(negedge clk);
    periph_out = rand_byte();
    periph_oe  = rand_byte();
    mio_in     = rand_byte();
    r          = rand_byte();
    jtag_tdo   = r[0];
    @(posedge clk);
    check_datapath();
  endtask

  task automatic randomize_config();
    for (int a = 0; a < `IO_ADDR_STATUS; a++) program_reg(5'(a), rand_byte());
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    seed       = 32'h7ebce826;
    clk        = 1'b0;
    rst_n      = 1'b0;
    reg_we     = 1'b0;
    reg_re     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    jtag_tdo   = 1'b0;
    periph_out = '0;
    periph_oe  = '0;
    mio_in     = '0;
    err_cnt    = 0;
    chk_cnt    = 0;
    status_ok  = 1'b0;

    // Reset state with the strap low
    apply_reset(1'b0);
    wait_status(1'b0, status_ok);
    if (status_ok) begin
      check_datapath();
      repeat (4) drive_and_check();
      read_and_check(`IO_ADDR_STATUS);

      // Register read-back
      for (int a = 0; a < `IO_ADDR_STATUS; a++) begin
        program_reg(5'(a), rand_byte());
        read_and_check(5'(a));
      end
      program_reg(`IO_ADDR_STATUS, 8'hff);  // Read-only
      read_and_check(`IO_ADDR_STATUS);
      for (int a = `IO_ADDR_STATUS + 1; a < 32; a++) begin
        program_reg(5'(a), rand_byte());
        read_and_check(5'(a));
      end
      for (int a = 0; a < `IO_ADDR_STATUS; a++) read_and_check(5'(a));

      // Output and input routing with random selects and attributes
      repeat (6) begin
        randomize_config();
        repeat (8) drive_and_check();
      end

      // JTAG overlay with the strap high through reset
      apply_reset(1'b1);
      wait_status(1'b1, status_ok);
    end

    if (status_ok) begin
      for (int k = 0; k < N; k++) begin
        program_reg(5'(`IO_ADDR_OUTSEL + k), 8'(k + 1));
        program_reg(5'(`IO_ADDR_INSEL + k), 8'(k + 1));  // Peripheral k sees pad k
      end
      repeat (16) drive_and_check();
      repeat (2) begin
        randomize_config();
        repeat (8) drive_and_check();
      end
    end

    finish_run();
  end

endmodule : io_subsys_tb

// File: compile.f
+incdir+rtl
rtl/io_pkg.sv
rtl/io_ctrl.sv
rtl/pin_mux.sv
rtl/jtag_mux.sv
rtl/pad_ring.sv
rtl/io_subsys_top.sv
sim/io_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the I/O subsystem testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=io_subsys_tb

verilator --binary --assert -f compile.f --top-module "$TOP" -Mdir "$OBJ_DIR"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
